/* hdl/arcade_pkg.sv */
package arcade_pkg;

	// keyboard scan codes
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_COIN   = 8'h76; // esc
	localparam logic [7:0] SC_START1 = 8'h05; // f1
	localparam logic [7:0] SC_START2 = 8'h06; // f2
	localparam logic [7:0] SC_FIRE   = 8'h29; // space

	// status word bits from the osd menu
	localparam int ST_RESET       = 0;
	localparam int ST_ROTATE      = 2;
	localparam int ST_OVERLAY_OFF = 5;
	localparam int ST_RESET_MENU  = 6;

	// board button used as reset
	localparam int BTN_RESET = 1;

	// joystick bits
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// pixel column counter
	localparam int COL_W = 9;

	// cellophane bands, in columns after hsync
	localparam logic [COL_W-1:0] OVL_GREEN_LO = 9'd16;
	localparam logic [COL_W-1:0] OVL_GREEN_HI = 9'd72;
	localparam logic [COL_W-1:0] OVL_RED_LO   = 9'd224;

	// game sound sample width
	localparam int AUDIO_W = 8;

endpackage

/* hdl/key_buttons_if.sv */
`timescale 1ns/1ps

interface key_buttons_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;
	logic coin;
	logic start1;
	logic start2;

	modport source (
		output up, down, left, right, fire, coin, start1, start2
	);

	modport sink (
		input up, down, left, right, fire, coin, start1, start2
	);
endinterface

/* hdl/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder import arcade_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 key_strobe,
	input  logic                 key_pressed,
	input  logic [7:0]           key_code,
	key_buttons_if.source        keys
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			keys.up     <= 1'b0;
			keys.down   <= 1'b0;
			keys.left   <= 1'b0;
			keys.right  <= 1'b0;
			keys.fire   <= 1'b0;
			keys.coin   <= 1'b0;
			keys.start1 <= 1'b0;
			keys.start2 <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				SC_UP:     keys.up     <= key_pressed;
				SC_DOWN:   keys.down   <= key_pressed;
				SC_LEFT:   keys.left   <= key_pressed;
				SC_RIGHT:  keys.right  <= key_pressed;
				SC_FIRE:   keys.fire   <= key_pressed;
				SC_COIN:   keys.coin   <= key_pressed;
				SC_START1: keys.start1 <= key_pressed;
				SC_START2: keys.start2 <= key_pressed;
				default: ; // other keys ignored
			endcase
		end
	end

	// user-io must present a clean code with every strobe
	a_code_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		key_strobe |-> !$isunknown(key_code)
	);

endmodule

/* hdl/input_mapper.sv */
`timescale 1ns/1ps

module input_mapper import arcade_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	key_buttons_if.sink keys,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic [31:0] status,
	input  logic [1:0]  buttons,
	output logic        ctl_up,
	output logic        ctl_down,
	output logic        ctl_left,
	output logic        ctl_right,
	output logic        ctl_fire,
	output logic        ctl_coin,
	output logic        ctl_start1,
	output logic        ctl_start2,
	output logic        game_reset
);

	logic phys_up, phys_down, phys_left, phys_right, phys_fire;
	logic rotate;

	assign phys_up    = keys.up    | joystick_0[JOY_UP]    | joystick_1[JOY_UP];
	assign phys_down  = keys.down  | joystick_0[JOY_DOWN]  | joystick_1[JOY_DOWN];
	assign phys_left  = keys.left  | joystick_0[JOY_LEFT]  | joystick_1[JOY_LEFT];
	assign phys_right = keys.right | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
	assign phys_fire  = keys.fire  | joystick_0[JOY_FIRE]  | joystick_1[JOY_FIRE];

	assign rotate = status[ST_ROTATE]; // set means no turn

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctl_up     <= 1'b0;
			ctl_down   <= 1'b0;
			ctl_left   <= 1'b0;
			ctl_right  <= 1'b0;
			ctl_fire   <= 1'b0;
			ctl_coin   <= 1'b0;
			ctl_start1 <= 1'b0;
			ctl_start2 <= 1'b0;
			game_reset <= 1'b1;
		end else begin
			ctl_up     <= rotate ? phys_up    : phys_right; // turned monitor
			ctl_down   <= rotate ? phys_down  : phys_left;
			ctl_left   <= rotate ? phys_left  : phys_up;
			ctl_right  <= rotate ? phys_right : phys_down;
			ctl_fire   <= phys_fire;
			ctl_coin   <= keys.coin;
			ctl_start1 <= keys.start1;
			ctl_start2 <= keys.start2;
			game_reset <= status[ST_RESET] | status[ST_RESET_MENU] | buttons[BTN_RESET];
		end
	end

	// the core must come out of a board reset still held in reset
	a_reset_held: assert property (@(posedge clk_sys) reset |=> game_reset);

endmodule

/* hdl/color_overlay.sv */
`timescale 1ns/1ps

module color_overlay import arcade_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic video,
	input  logic hsync,
	input  logic vsync,
	input  logic overlay_off,
	output logic vid_r,
	output logic vid_g,
	output logic vid_b,
	output logic vid_hs,
	output logic vid_vs
);

	logic [COL_W-1:0] col;
	logic             hs_prev;
	logic             hs_rise;
	logic             video_q;
	logic             in_green;
	logic             in_red;
	logic [2:0]       rgb; // r, g, b

	assign hs_rise = hsync & ~hs_prev;

	// column count from the start of the line
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_prev <= 1'b0;
			col     <= '0;
		end else begin
			hs_prev <= hsync;
			if (hs_rise)
				col <= '0;
			else if (col != {COL_W{1'b1}})
				col <= col + 1'b1; // hold at max
		end
	end

	assign in_green = (col >= OVL_GREEN_LO) && (col < OVL_GREEN_HI);
	assign in_red   = (col >= OVL_RED_LO);

	always_comb begin
		if (!video)
			rgb = 3'b000;
		else if (overlay_off)
			rgb = 3'b111;
		else if (in_green)
			rgb = 3'b010;
		else if (in_red)
			rgb = 3'b100;
		else
			rgb = 3'b111; // plain white strip
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{vid_r, vid_g, vid_b} <= 3'b000;
			vid_hs  <= 1'b0;
			vid_vs  <= 1'b0;
			video_q <= 1'b0;
		end else begin
			{vid_r, vid_g, vid_b} <= rgb;
			vid_hs  <= hsync; // same delay as colour
			vid_vs  <= vsync;
			video_q <= video;
		end
	end

	a_black_when_off: assert property (
		@(posedge clk_sys) disable iff (reset)
		!video_q |-> !(vid_r | vid_g | vid_b)
	);

endmodule

/* hdl/audio_dac.sv */
`timescale 1ns/1ps

module audio_dac import arcade_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [AUDIO_W-1:0] audio,
	output logic               audio_out
);

	// top bit holds the carry of the last add
	logic [AUDIO_W:0] acc;
	logic [AUDIO_W:0] sum;

	// carry dropped before the next add
	assign sum = {1'b0, acc[AUDIO_W-1:0]} + {1'b0, audio};

	always_ff @(posedge clk_sys) begin
		if (reset)
			acc <= '0;
		else
			acc <= sum;
	end

	assign audio_out = acc[AUDIO_W]; // flop output

endmodule

/* hdl/arcade_shell.sv */
`timescale 1ns/1ps

module arcade_shell import arcade_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               key_strobe,
	input  logic               key_pressed,
	input  logic [7:0]         key_code,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic [31:0]        status,
	input  logic [1:0]         buttons,
	input  logic               video,
	input  logic               hsync,
	input  logic               vsync,
	input  logic [AUDIO_W-1:0] audio,
	output logic               ctl_up,
	output logic               ctl_down,
	output logic               ctl_left,
	output logic               ctl_right,
	output logic               ctl_fire,
	output logic               ctl_coin,
	output logic               ctl_start1,
	output logic               ctl_start2,
	output logic               game_reset,
	output logic               vid_r,
	output logic               vid_g,
	output logic               vid_b,
	output logic               vid_hs,
	output logic               vid_vs,
	output logic               audio_out
);

	key_buttons_if keys ();

	key_decoder u_key_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.keys        (keys.source)
	);

	input_mapper u_input_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.keys       (keys.sink),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.buttons    (buttons),
		.ctl_up     (ctl_up),
		.ctl_down   (ctl_down),
		.ctl_left   (ctl_left),
		.ctl_right  (ctl_right),
		.ctl_fire   (ctl_fire),
		.ctl_coin   (ctl_coin),
		.ctl_start1 (ctl_start1),
		.ctl_start2 (ctl_start2),
		.game_reset (game_reset)
	);

	color_overlay u_color_overlay (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.video       (video),
		.hsync       (hsync),
		.vsync       (vsync),
		.overlay_off (status[ST_OVERLAY_OFF]), // osd "overlay off"
		.vid_r       (vid_r),
		.vid_g       (vid_g),
		.vid_b       (vid_b),
		.vid_hs      (vid_hs),
		.vid_vs      (vid_vs)
	);

	audio_dac u_audio_dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.audio     (audio),
		.audio_out (audio_out)
	);

endmodule

/* tests/arcade_shell_tb.sv */
`timescale 1ns/1ps

module arcade_shell_tb import arcade_pkg::*; ();

	typedef enum logic [1:0] {KIND_KEY, KIND_LEVEL, KIND_VID, KIND_AUD} kind_e;

	// each row holds kind, stimulus and expected values
	typedef struct packed {
		kind_e       kind;
		logic [7:0]  code;
		logic        pressed;
		logic [7:0]  j0;
		logic [7:0]  j1;
		logic [31:0] st;
		logic [1:0]  btn;
		logic [8:0]  col;
		logic        vs;
		logic [7:0]  aud;
		logic [7:0]  exp_ctl; // start2 start1 coin fire right left down up
		logic        exp_rst;
		logic [2:0]  exp_rgb;
	} entry_t;

	logic clk_sys = 1'b0;
	logic reset, key_strobe, key_pressed, video, hsync, vsync;
	logic [7:0] key_code, joystick_0, joystick_1, audio;
	logic [31:0] status;
	logic [1:0] buttons;
	logic ctl_up, ctl_down, ctl_left, ctl_right, ctl_fire, ctl_coin, ctl_start1, ctl_start2;
	logic game_reset, vid_r, vid_g, vid_b, vid_hs, vid_vs, audio_out;
	logic [7:0] ctl_vec;
	logic [31:0] rng = 32'd41754;
	entry_t tbl[$];
	logic table_ready = 1'b0;

	assign ctl_vec = {ctl_start2, ctl_start1, ctl_coin, ctl_fire,
		ctl_right, ctl_left, ctl_down, ctl_up};

	always #10 clk_sys = ~clk_sys;

	arcade_shell DUT (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// k holds key levels in the ctl_vec order
	function automatic logic [7:0] ctl_ref(input logic [7:0] k, input logic [7:0] j0,
		input logic [7:0] j1, input logic rot);
		logic pu, pd, pl, pr, pf;
		pu = k[0] | j0[JOY_UP] | j1[JOY_UP];
		pd = k[1] | j0[JOY_DOWN] | j1[JOY_DOWN];
		pl = k[2] | j0[JOY_LEFT] | j1[JOY_LEFT];
		pr = k[3] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		pf = k[4] | j0[JOY_FIRE] | j1[JOY_FIRE];
		if (rot)
			return {k[7:5], pf, pr, pl, pd, pu};
		return {k[7:5], pf, pd, pu, pl, pr}; // monitor turned
	endfunction

	function automatic logic reset_ref(input logic [31:0] st, input logic [1:0] b);
		return st[ST_RESET] | st[ST_RESET_MENU] | b[BTN_RESET];
	endfunction

	function automatic logic [2:0] rgb_ref(input logic [8:0] col, input logic off);
		if (off)
			return 3'b111;
		if (col >= OVL_GREEN_LO && col < OVL_GREEN_HI)
			return 3'b010;
		if (col >= OVL_RED_LO)
			return 3'b100;
		return 3'b111;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic add_key(inout logic [7:0] ks, input logic [7:0] code, input int idx,
		input logic pressed, input logic rot);
		entry_t e;
		e = '0;
		if (idx >= 0)
			ks[idx] = pressed;
		e.kind = KIND_KEY;
		e.code = code;
		e.pressed = pressed;
		e.st[ST_ROTATE] = rot;
		e.exp_ctl = ctl_ref(ks, 8'h00, 8'h00, rot);
		tbl.push_back(e);
	endtask

	task automatic build_table;
		entry_t e;
		logic [7:0] ks;
		logic [7:0] codes [8];
		logic [8:0] cols [11];
		ks = '0;
		codes = '{SC_UP, SC_DOWN, SC_LEFT, SC_RIGHT, SC_FIRE, SC_COIN, SC_START1, SC_START2};
		cols = '{9'd8, 9'd16, 9'd40, 9'd71, 9'd72, 9'd150, 9'd223, 9'd224, 9'd300,
			9'd40, 9'd230};
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 8; i++) begin
				add_key(ks, codes[i], i, 1'b1, r[0]);
				add_key(ks, codes[i], i, 1'b0, r[0]);
			end
		end
		add_key(ks, SC_LEFT, 2, 1'b1, 1'b0);
		add_key(ks, 8'h1C, -1, 1'b1, 1'b0); // unknown code
		add_key(ks, 8'h1C, -1, 1'b0, 1'b0);
		add_key(ks, SC_LEFT, 2, 1'b0, 1'b0);
		for (int i = 0; i < 15; i++) begin
			e = '0;
			e.kind = KIND_LEVEL;
			if (i < 8) begin
				rng = xorshift(rng);
				e.j0 = rng[7:0];
				e.j1 = rng[15:8];
				e.st[ST_ROTATE] = i[0];
			end else if (i == 8)
				e.st[ST_RESET] = 1'b1;
			else if (i == 10)
				e.st[ST_RESET_MENU] = 1'b1;
			else if (i == 12)
				e.btn[BTN_RESET] = 1'b1;
			else if (i == 14)
				e.btn = 2'b01; // other button does not reset
			e.exp_ctl = ctl_ref(ks, e.j0, e.j1, e.st[ST_ROTATE]);
			e.exp_rst = reset_ref(e.st, e.btn);
			tbl.push_back(e);
		end
		for (int i = 0; i < 11; i++) begin
			e = '0;
			e.kind = KIND_VID;
			e.col = cols[i];
			e.vs = i[0];
			e.st[ST_OVERLAY_OFF] = (i >= 9);
			e.exp_rgb = rgb_ref(e.col, e.st[ST_OVERLAY_OFF]);
			tbl.push_back(e);
		end
		for (int i = 0; i < 4; i++) begin
			e = '0;
			e.kind = KIND_AUD;
			rng = xorshift(rng);
			e.aud = rng[7:0];
			tbl.push_back(e);
		end
	endtask

	task automatic drive_common(input entry_t e);
		status <= e.st;
		buttons <= e.btn;
		joystick_0 <= e.j0;
		joystick_1 <= e.j1;
	endtask

	task automatic run_key(input entry_t e);
		@(posedge clk_sys);
		drive_common(e);
		key_strobe <= 1'b1;
		key_code <= e.code;
		key_pressed <= e.pressed;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
		@(posedge clk_sys); // decoder then mapper
		@(negedge clk_sys);
		check_value("ctl", ctl_vec, e.exp_ctl);
	endtask

	task automatic run_level(input entry_t e);
		@(posedge clk_sys);
		drive_common(e);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("ctl", ctl_vec, e.exp_ctl);
		check_value("game_reset", game_reset, e.exp_rst);
	endtask

	task automatic run_vid(input entry_t e);
		@(posedge clk_sys);
		drive_common(e);
		hsync <= 1'b0;
		vsync <= !e.vs;
		video <= 1'b1;
		@(posedge clk_sys);
		hsync <= 1'b1;
		vsync <= e.vs;
		@(negedge clk_sys);
		check_value("vid_hs", vid_hs, 1'b0); // still the old hsync
		check_value("vid_vs", vid_vs, !e.vs);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("vid_hs", vid_hs, 1'b1);
		check_value("vid_vs", vid_vs, e.vs);
		repeat (e.col + 1) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("vid_rgb", {vid_r, vid_g, vid_b}, e.exp_rgb);
		check_value("vid_hs", vid_hs, 1'b1);
		check_value("vid_vs", vid_vs, e.vs);
	endtask

	task automatic run_aud(input entry_t e);
		int ones;
		@(posedge clk_sys);
		drive_common(e);
		audio <= e.aud;
		repeat (256) @(posedge clk_sys);
		ones = 0;
		repeat (256) begin
			@(negedge clk_sys);
			ones += audio_out;
		end
		check_value("audio_out ones", ones, e.aud);
	endtask

	initial begin
		wait (table_ready);
		#(tbl.size() * 300 * 20);
		$display("Timeout: the tests did not finish in the time allowed for %0d entries",
			tbl.size());
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		reset = 1'b1;
		{key_strobe, key_pressed, video, hsync, vsync} = '0;
		{key_code, joystick_0, joystick_1, audio} = '0;
		status = '0;
		buttons = '0;
		build_table();
		table_ready = 1'b1;
		repeat (7) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("ctl", ctl_vec, 8'h00);
		check_value("vid", {vid_r, vid_g, vid_b, vid_hs, vid_vs}, 5'b0);
		check_value("audio_out", audio_out, 1'b0);
		check_value("game_reset", game_reset, 1'b1);
		@(posedge clk_sys);
		reset <= 1'b0; // after the 8th edge
		@(negedge clk_sys);
		check_value("game_reset", game_reset, 1'b1);
		@(negedge clk_sys);
		check_value("game_reset", game_reset, 1'b0);
		foreach (tbl[i]) begin
			case (tbl[i].kind)
				KIND_KEY:   run_key(tbl[i]);
				KIND_LEVEL: run_level(tbl[i]);
				KIND_VID:   run_vid(tbl[i]);
				KIND_AUD:   run_aud(tbl[i]);
			endcase
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* tb.f */
hdl/arcade_pkg.sv
hdl/key_buttons_if.sv
hdl/key_decoder.sv
hdl/input_mapper.sv
hdl/color_overlay.sv
hdl/audio_dac.sv
hdl/arcade_shell.sv
tests/arcade_shell_tb.sv

/* Bender.yml */
package:
  name: arcade_shell

sources:
  - hdl/arcade_pkg.sv
  - hdl/key_buttons_if.sv
  - hdl/key_decoder.sv
  - hdl/input_mapper.sv
  - hdl/color_overlay.sv
  - hdl/audio_dac.sv
  - hdl/arcade_shell.sv
  - target: simulation
    files:
      - tests/arcade_shell_tb.sv
